// File: source/cache_req_pkg.sv
// Sizes fixed for three requestors, 32-bit addresses, a 16-deep FIFO; change here only
package cache_req_pkg;

  // ------------------------------------------------
  // Requestor and arbiter sizes
  // ------------------------------------------------
  localparam int NUM_REQUESTORS = 3;
  // Arbiter width rounded up to a power of two
  localparam int NUM_ARB_SLOTS  = 4;
  // Requestor index, wide enough for every arbiter slot
  localparam int SRC_W          = 2;

  // ------------------------------------------------
  // Memory word sizes
  // ------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One strobe bit per data byte
  localparam int STRB_W = 4;

  // ------------------------------------------------
  // Buffer descriptors
  // ------------------------------------------------
  // One-hot buffer select carried by each packet
  localparam int BUF_ID_W    = 3;
  // buffer_0 to buffer_3
  localparam int NUM_BUFFERS = 4;
  localparam int BUF_INDEX_W = 2;

  // ------------------------------------------------
  // Request FIFO sizing and thresholds
  // ------------------------------------------------
  localparam int FIFO_DEPTH       = 16;
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
  // Count needs one more bit to hold a full FIFO
  localparam int FIFO_CNT_W       = FIFO_PTR_W + 1;
  // Leaves room for the two packets still in the pipeline
  localparam int PROG_FULL_THRESH = 12;

  // ------------------------------------------------
  // Packet commands
  // ------------------------------------------------
  // Only the two memory commands reach the cache
  typedef enum logic [2:0] {
    CMD_INVALID      = 3'd0,
    CMD_MEM_READ     = 3'd1,
    CMD_MEM_WRITE    = 3'd2,
    CMD_MEM_RESPONSE = 3'd3,
    CMD_ENGINE       = 3'd4
  } cmd_t;

  // One cache request as stored in the FIFO
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    cmd_t              cmd;
    // Requestor that issued the packet
    logic [SRC_W-1:0]  source;
  } cache_entry_t;

endpackage : cache_req_pkg

// File: source/buffer_descriptor_regs.sv
// Base is zero until all four registers are written after reset; one write per cycle
module buffer_descriptor_regs (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  logic                                 desc_wr_en,
  input  logic [cache_req_pkg::BUF_INDEX_W-1:0] desc_wr_index,
  input  logic [cache_req_pkg::ADDR_W-1:0]      desc_wr_base,
  input  logic [cache_req_pkg::BUF_ID_W-1:0]    sel_buffer_id,
  output logic [cache_req_pkg::ADDR_W-1:0]      sel_base
);

  // ------------------------------------------------
  // Base registers and written flags
  // ------------------------------------------------
  logic [cache_req_pkg::ADDR_W-1:0]      base_q [cache_req_pkg::NUM_BUFFERS];
  logic [cache_req_pkg::NUM_BUFFERS-1:0] written_q;

  // Flags track which bases hold a real value
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      written_q <= '0;
    end else if (desc_wr_en) begin
      written_q[desc_wr_index] <= 1'b1;
    end
  end

  // Base values themselves
  always_ff @(posedge ap_clk) begin
    if (desc_wr_en) begin
      base_q[desc_wr_index] <= desc_wr_base;
    end
  end

  // ------------------------------------------------
  // Buffer select decode
  // ------------------------------------------------
  always_comb begin
    sel_base = '0;
    // Descriptor incomplete, keep base at zero
    if (&written_q) begin
      case (sel_buffer_id)
        3'b001:  sel_base = base_q[1];
        3'b010:  sel_base = base_q[2];
        3'b100:  sel_base = base_q[3];
        // No bit or several bits set
        default: sel_base = base_q[0];
      endcase
    end
  end

endmodule : buffer_descriptor_regs

// File: source/request_arbiter.sv
// Requestors must hold packets until granted; no grant while hold is high
module request_arbiter (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  logic                                  hold,
  input  logic [cache_req_pkg::NUM_REQUESTORS-1:0] req_valid,
  input  cache_req_pkg::cmd_t req_cmd [cache_req_pkg::NUM_REQUESTORS],
  input  logic [cache_req_pkg::BUF_ID_W-1:0] req_buffer_id [cache_req_pkg::NUM_REQUESTORS],
  input  logic [cache_req_pkg::ADDR_W-1:0] req_offset [cache_req_pkg::NUM_REQUESTORS],
  input  logic [cache_req_pkg::DATA_W-1:0] req_wdata [cache_req_pkg::NUM_REQUESTORS],
  output logic [cache_req_pkg::NUM_REQUESTORS-1:0] req_grant,
  output logic                                  win_valid,
  output cache_req_pkg::cmd_t                   win_cmd,
  output logic [cache_req_pkg::BUF_ID_W-1:0]    win_buffer_id,
  output logic [cache_req_pkg::ADDR_W-1:0]      win_offset,
  output logic [cache_req_pkg::DATA_W-1:0]      win_wdata,
  output logic [cache_req_pkg::SRC_W-1:0]       win_source
);

  // ------------------------------------------------
  // Requestors padded to the arbiter width
  // ------------------------------------------------
  logic [cache_req_pkg::NUM_ARB_SLOTS-1:0] slot_valid;
  cache_req_pkg::cmd_t slot_cmd [cache_req_pkg::NUM_ARB_SLOTS];
  logic [cache_req_pkg::BUF_ID_W-1:0] slot_buffer_id [cache_req_pkg::NUM_ARB_SLOTS];
  logic [cache_req_pkg::ADDR_W-1:0] slot_offset [cache_req_pkg::NUM_ARB_SLOTS];
  logic [cache_req_pkg::DATA_W-1:0] slot_wdata [cache_req_pkg::NUM_ARB_SLOTS];

  logic [cache_req_pkg::SRC_W-1:0]         last_idx;
  logic [cache_req_pkg::SRC_W-1:0]         cand;
  logic [cache_req_pkg::SRC_W-1:0]         pick_idx;
  logic                                    pick_found;
  logic                                    grant_ok;
  logic [cache_req_pkg::NUM_ARB_SLOTS-1:0] grant_vec;

  always_comb begin
    // Spare slots never request
    slot_valid = '0;
    for (int i = 0; i < cache_req_pkg::NUM_ARB_SLOTS; i++) begin
      slot_cmd[i]       = cache_req_pkg::CMD_INVALID;
      slot_buffer_id[i] = '0;
      slot_offset[i]    = '0;
      slot_wdata[i]     = '0;
    end
    for (int i = 0; i < cache_req_pkg::NUM_REQUESTORS; i++) begin
      slot_valid[i]     = req_valid[i];
      slot_cmd[i]       = req_cmd[i];
      slot_buffer_id[i] = req_buffer_id[i];
      slot_offset[i]    = req_offset[i];
      slot_wdata[i]     = req_wdata[i];
    end
  end

  // ------------------------------------------------
  // Round-robin pick
  // ------------------------------------------------
  // Search starts one past the last winner, last winner comes last
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    cand       = '0;
    for (int k = 1; k <= cache_req_pkg::NUM_ARB_SLOTS; k++) begin
      cand = last_idx + k[cache_req_pkg::SRC_W-1:0];
      if (!pick_found && slot_valid[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  assign grant_ok = pick_found & ~hold;

  always_comb begin
    grant_vec = '0;
    if (grant_ok) begin
      grant_vec[pick_idx] = 1'b1;
    end
  end

  // ------------------------------------------------
  // Grant and winner registers
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_grant <= '0;
      win_valid <= 1'b0;
      // First search then starts at slot 0
      last_idx  <= '1;
    end else begin
      req_grant <= grant_vec[cache_req_pkg::NUM_REQUESTORS-1:0];
      win_valid <= grant_ok;
      if (grant_ok) begin
        last_idx <= pick_idx;
      end
    end
  end

  // Winner payload
  always_ff @(posedge ap_clk) begin
    if (grant_ok) begin
      win_cmd       <= slot_cmd[pick_idx];
      win_buffer_id <= slot_buffer_id[pick_idx];
      win_offset    <= slot_offset[pick_idx];
      win_wdata     <= slot_wdata[pick_idx];
      win_source    <= pick_idx;
    end
  end

  // At most one requestor granted per cycle
  assert property (@(posedge ap_clk) disable iff (areset_control) $onehot0(req_grant))
    else $error("request_arbiter: more than one grant");

endmodule : request_arbiter

// File: source/cache_request_builder.sv
// Translated address wraps at 32 bits; only read and write commands are pushed
module cache_request_builder (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               win_valid,
  input  cache_req_pkg::cmd_t                win_cmd,
  input  logic [cache_req_pkg::BUF_ID_W-1:0] win_buffer_id,
  input  logic [cache_req_pkg::ADDR_W-1:0]   win_offset,
  input  logic [cache_req_pkg::DATA_W-1:0]   win_wdata,
  input  logic [cache_req_pkg::SRC_W-1:0]    win_source,
  input  logic [cache_req_pkg::ADDR_W-1:0]   sel_base,
  output logic [cache_req_pkg::BUF_ID_W-1:0] sel_buffer_id,
  output logic                               push,
  output cache_req_pkg::cache_entry_t        push_entry
);

  // ------------------------------------------------
  // Request formation
  // ------------------------------------------------
  cache_req_pkg::cache_entry_t entry_next;
  logic                        keep;

  // Register block decodes the select for us
  assign sel_buffer_id = win_buffer_id;

  always_comb begin
    entry_next.addr   = sel_base + win_offset;
    entry_next.wdata  = win_wdata;
    entry_next.cmd    = win_cmd;
    entry_next.source = win_source;
    // Full word on writes, nothing on reads
    if (win_cmd == cache_req_pkg::CMD_MEM_WRITE) begin
      entry_next.wstrb = {cache_req_pkg::STRB_W{1'b1}};
    end else begin
      entry_next.wstrb = '0;
    end
  end

  // ------------------------------------------------
  // Command filter
  // ------------------------------------------------
  // Responses, engine traffic and invalid packets stop here
  assign keep = (win_cmd != cache_req_pkg::CMD_MEM_RESPONSE) &&
                (win_cmd != cache_req_pkg::CMD_ENGINE) &&
                (win_cmd != cache_req_pkg::CMD_INVALID);

  // ------------------------------------------------
  // Registered FIFO write side
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      push <= 1'b0;
    end else begin
      push <= win_valid & keep;
    end
  end

  // Entry captured only for real winners
  always_ff @(posedge ap_clk) begin
    if (win_valid) begin
      push_entry <= entry_next;
    end
  end

endmodule : cache_request_builder

// File: source/request_fifo.sv
// Depth must be a power of two; upstream must stop pushing once prog_full is seen
module request_fifo #(
  parameter type entry_t = logic [7:0]
) (
  input  logic   ap_clk,
  input  logic   areset_control,
  input  logic   push,
  input  entry_t push_entry,
  input  logic   pop_ready,
  output logic   pop,
  output entry_t pop_entry,
  output logic   prog_full,
  output logic   fifo_setup
);

  // ------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------
  entry_t                               mem [cache_req_pkg::FIFO_DEPTH];
  logic [cache_req_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [cache_req_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [cache_req_pkg::FIFO_CNT_W-1:0] count;
  logic [cache_req_pkg::FIFO_CNT_W-1:0] count_next;
  logic                                 empty;
  logic                                 full;

  assign empty = (count == '0);
  assign full  = (count == cache_req_pkg::FIFO_DEPTH);

  // Pop whenever the consumer is ready and data waits
  assign pop       = ~empty & pop_ready;
  // Head is visible in the pop cycle
  assign pop_entry = mem[rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  // ------------------------------------------------
  // Occupancy
  // ------------------------------------------------
  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      prog_full  <= 1'b0;
      // Held through reset and one cycle beyond
      fifo_setup <= 1'b1;
    end else begin
      fifo_setup <= 1'b0;
      count      <= count_next;
      // Pointers wrap naturally at the power-of-two depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      prog_full <= (count_next >= cache_req_pkg::PROG_FULL_THRESH);
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // Relies on the arbiter stopping early enough on prog_full
  assert property (@(posedge ap_clk) disable iff (areset_control) push |-> !full)
    else $error("request_fifo: push while full");

  // Pointers and count must agree that data is waiting
  assert property (@(posedge ap_clk) disable iff (areset_control)
    pop |-> ((wr_ptr != rd_ptr) || full))
    else $error("request_fifo: pop while empty");

endmodule : request_fifo

// File: source/cache_request_generator.sv
// Three requestors, one cache port; arbiter holds off during FIFO setup and on prog_full
module cache_request_generator (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  logic [cache_req_pkg::NUM_REQUESTORS-1:0] req_valid,
  input  cache_req_pkg::cmd_t req_cmd [cache_req_pkg::NUM_REQUESTORS],
  input  logic [cache_req_pkg::BUF_ID_W-1:0] req_buffer_id [cache_req_pkg::NUM_REQUESTORS],
  input  logic [cache_req_pkg::ADDR_W-1:0] req_offset [cache_req_pkg::NUM_REQUESTORS],
  input  logic [cache_req_pkg::DATA_W-1:0] req_wdata [cache_req_pkg::NUM_REQUESTORS],
  output logic [cache_req_pkg::NUM_REQUESTORS-1:0] req_grant,
  input  logic                                  desc_wr_en,
  input  logic [cache_req_pkg::BUF_INDEX_W-1:0] desc_wr_index,
  input  logic [cache_req_pkg::ADDR_W-1:0]      desc_wr_base,
  input  logic                                  cache_ready,
  output logic                                  cache_valid,
  output logic [cache_req_pkg::ADDR_W-1:0]      cache_addr,
  output logic [cache_req_pkg::DATA_W-1:0]      cache_wdata,
  output logic [cache_req_pkg::STRB_W-1:0]      cache_wstrb,
  output cache_req_pkg::cmd_t                   cache_cmd,
  output logic [cache_req_pkg::SRC_W-1:0]       cache_source,
  output logic                                  prog_full,
  output logic                                  fifo_setup
);

  // ------------------------------------------------
  // Internal wiring
  // ------------------------------------------------
  logic                               hold;
  logic                               win_valid;
  cache_req_pkg::cmd_t                win_cmd;
  logic [cache_req_pkg::BUF_ID_W-1:0] win_buffer_id;
  logic [cache_req_pkg::ADDR_W-1:0]   win_offset;
  logic [cache_req_pkg::DATA_W-1:0]   win_wdata;
  logic [cache_req_pkg::SRC_W-1:0]    win_source;
  logic [cache_req_pkg::BUF_ID_W-1:0] sel_buffer_id;
  logic [cache_req_pkg::ADDR_W-1:0]   sel_base;
  logic                               push;
  cache_req_pkg::cache_entry_t        push_entry;
  logic                               pop;
  cache_req_pkg::cache_entry_t        pop_entry;

  // Back-pressure and setup both stall the arbiter
  assign hold = prog_full | fifo_setup;

  buffer_descriptor_regs u_desc_regs (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .desc_wr_en    (desc_wr_en),
    .desc_wr_index (desc_wr_index),
    .desc_wr_base  (desc_wr_base),
    .sel_buffer_id (sel_buffer_id),
    .sel_base      (sel_base)
  );

  request_arbiter u_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .hold          (hold),
    .req_valid     (req_valid),
    .req_cmd       (req_cmd),
    .req_buffer_id (req_buffer_id),
    .req_offset    (req_offset),
    .req_wdata     (req_wdata),
    .req_grant     (req_grant),
    .win_valid     (win_valid),
    .win_cmd       (win_cmd),
    .win_buffer_id (win_buffer_id),
    .win_offset    (win_offset),
    .win_wdata     (win_wdata),
    .win_source    (win_source)
  );

  cache_request_builder u_builder (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .win_valid     (win_valid),
    .win_cmd       (win_cmd),
    .win_buffer_id (win_buffer_id),
    .win_offset    (win_offset),
    .win_wdata     (win_wdata),
    .win_source    (win_source),
    .sel_base      (sel_base),
    .sel_buffer_id (sel_buffer_id),
    .push          (push),
    .push_entry    (push_entry)
  );

  request_fifo #(
    .entry_t(cache_req_pkg::cache_entry_t)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push          (push),
    .push_entry    (push_entry),
    .pop_ready     (cache_ready),
    .pop           (pop),
    .pop_entry     (pop_entry),
    .prog_full     (prog_full),
    .fifo_setup    (fifo_setup)
  );

  // ------------------------------------------------
  // Registered cache port
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      cache_valid <= 1'b0;
    end else begin
      cache_valid <= pop;
    end
  end

  // Payload follows each pop
  always_ff @(posedge ap_clk) begin
    if (pop) begin
      cache_addr   <= pop_entry.addr;
      cache_wdata  <= pop_entry.wdata;
      cache_wstrb  <= pop_entry.wstrb;
      cache_cmd    <= pop_entry.cmd;
      cache_source <= pop_entry.source;
    end
  end

endmodule : cache_request_generator

// File: tb/tb_cache_request_generator.sv
// Directed tests; descriptor bases change only while the DUT is idle, one grant per cycle
module tb_cache_request_generator;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF    = 20;
  // About four times the summed length of the five tests
  localparam int MAX_CYCLES  = 2000;
  localparam int DRAIN_LIMIT = 100;

  // ------------------------------------------------
  // DUT signals
  // ------------------------------------------------
  logic                                        ap_clk;
  logic                                        areset_control;
  logic [cache_req_pkg::NUM_REQUESTORS-1:0]    req_valid;
  cache_req_pkg::cmd_t req_cmd [cache_req_pkg::NUM_REQUESTORS];
  logic [cache_req_pkg::BUF_ID_W-1:0] req_buffer_id [cache_req_pkg::NUM_REQUESTORS];
  logic [cache_req_pkg::ADDR_W-1:0] req_offset [cache_req_pkg::NUM_REQUESTORS];
  logic [cache_req_pkg::DATA_W-1:0] req_wdata [cache_req_pkg::NUM_REQUESTORS];
  logic [cache_req_pkg::NUM_REQUESTORS-1:0]    req_grant;
  logic                                        desc_wr_en;
  logic [cache_req_pkg::BUF_INDEX_W-1:0]       desc_wr_index;
  logic [cache_req_pkg::ADDR_W-1:0]            desc_wr_base;
  logic                                        cache_ready;
  logic                                        cache_valid;
  logic [cache_req_pkg::ADDR_W-1:0]            cache_addr;
  logic [cache_req_pkg::DATA_W-1:0]            cache_wdata;
  logic [cache_req_pkg::STRB_W-1:0]            cache_wstrb;
  cache_req_pkg::cmd_t                         cache_cmd;
  logic [cache_req_pkg::SRC_W-1:0]             cache_source;
  logic                                        prog_full;
  logic                                        fifo_setup;

  cache_request_generator DUT (.*);

  // Scoreboard in grant order, plus the bases as the tests wrote them
  cache_req_pkg::cache_entry_t expected_q [$];
  int                          grant_log [$];
  logic [31:0]                 tb_base [cache_req_pkg::NUM_BUFFERS];
  logic [cache_req_pkg::NUM_BUFFERS-1:0] tb_written;
  string test_name;
  int    error_count, check_count, test_count, test_fail_count, errors_at_start;
  int    out_count, grant_count, last_grant, cycle_count;

  always #CLK_HALF ap_clk = ~ap_clk;

  // Run limit
  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("mismatch %s %s: expected %0h actual %0h", test_name, field, expected, actual);
    end
  endtask

  // Cache port sampled mid-cycle, away from the edge
  always @(negedge ap_clk) begin
    cache_req_pkg::cache_entry_t exp_e;
    if (!areset_control && cache_valid) begin
      out_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("error in %s: cache request at %0h came out with none expected",
                 test_name, cache_addr);
      end else begin
        exp_e = expected_q.pop_front();
        check_value("addr", exp_e.addr, cache_addr);
        check_value("wdata", exp_e.wdata, cache_wdata);
        check_value("wstrb", 32'(exp_e.wstrb), 32'(cache_wstrb));
        check_value("cmd", 32'(exp_e.cmd), 32'(cache_cmd));
        check_value("source", 32'(exp_e.source), 32'(cache_source));
      end
    end
  end

  // Grant pulses counted straight off the DUT port
  always @(negedge ap_clk) begin
    if (!areset_control) begin
      grant_count += $countones(req_grant);
    end
  end

  task automatic next_cycle();
    @(posedge ap_clk);
    #2;
  endtask

  function automatic logic is_memory_cmd(input cache_req_pkg::cmd_t cmd);
    return (cmd == cache_req_pkg::CMD_MEM_READ) || (cmd == cache_req_pkg::CMD_MEM_WRITE);
  endfunction

  // Zero until all four bases are written, then one-hot select, else buffer_0
  function automatic logic [31:0] expected_base(input logic [2:0] buf_id);
    if (tb_written != 4'b1111) begin
      return 32'h0;
    end
    case (buf_id)
      3'b001:  return tb_base[1];
      3'b010:  return tb_base[2];
      3'b100:  return tb_base[3];
      default: return tb_base[0];
    endcase
  endfunction

  function automatic cache_req_pkg::cache_entry_t build_expected(input int idx,
      input cache_req_pkg::cmd_t cmd, input logic [2:0] buf_id,
      input logic [31:0] offset, input logic [31:0] wdata);
    cache_req_pkg::cache_entry_t e;
    e.addr   = expected_base(buf_id) + offset;
    e.wdata  = wdata;
    e.wstrb  = (cmd == cache_req_pkg::CMD_MEM_WRITE) ? 4'hf : 4'h0;
    e.cmd    = cmd;
    e.source = 2'(idx);
    return e;
  endfunction

  // Holds the packet until granted, then logs the grant
  task automatic send_packet(input int idx, input cache_req_pkg::cmd_t cmd,
                             input logic [2:0] buf_id);
    logic [31:0] offset;
    logic [31:0] wdata;
    offset             = $urandom;
    wdata              = $urandom;
    req_cmd[idx]       = cmd;
    req_buffer_id[idx] = buf_id;
    req_offset[idx]    = offset;
    req_wdata[idx]     = wdata;
    req_valid[idx]     = 1'b1;
    do begin
      next_cycle();
    end while (!req_grant[idx]);
    grant_log.push_back(idx);
    last_grant = idx;
    if (is_memory_cmd(cmd)) begin
      expected_q.push_back(build_expected(idx, cmd, buf_id, offset, wdata));
    end
    req_valid[idx] = 1'b0;
  endtask

  task automatic send_burst(input int idx, input int count);
    cache_req_pkg::cmd_t cmd;
    for (int n = 0; n < count; n++) begin
      cmd = ($urandom_range(1, 0) == 1) ? cache_req_pkg::CMD_MEM_WRITE
                                        : cache_req_pkg::CMD_MEM_READ;
      send_packet(idx, cmd, 3'($urandom_range(7, 0)));
    end
  endtask

  task automatic write_base(input int index, input logic [31:0] base);
    desc_wr_en    = 1'b1;
    desc_wr_index = 2'(index);
    desc_wr_base  = base;
    next_cycle();
    desc_wr_en        = 1'b0;
    tb_base[index]    = base;
    tb_written[index] = 1'b1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (expected_q.size() != 0) begin
      error_count++;
      $display("error in %s: %0d expected requests never reached the cache port",
               test_name, expected_q.size());
      expected_q.delete();
    end
    // Room for any stray output to show
    repeat (4) next_cycle();
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic finish_test();
    if (error_count == errors_at_start) begin
      $display("test %s: pass", test_name);
    end else begin
      test_fail_count++;
      $display("test %s: fail, %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task automatic test_reset();
    start_test("reset");
    repeat (4) next_cycle();
    check_value("fifo_setup in reset", 1, 32'(fifo_setup));
    areset_control = 1'b0;
    // First cycle out of reset, setup still high
    @(negedge ap_clk);
    check_value("fifo_setup after reset", 1, 32'(fifo_setup));
    next_cycle();
    check_value("fifo_setup", 0, 32'(fifo_setup));
    check_value("req_grant", 0, 32'(req_grant));
    check_value("cache_valid", 0, 32'(cache_valid));
    check_value("prog_full", 0, 32'(prog_full));
    finish_test();
  endtask

  task automatic test_translation();
    start_test("translation");
    // No bases yet, address is the bare offset
    send_packet(0, cache_req_pkg::CMD_MEM_READ, 3'b001);
    send_packet(0, cache_req_pkg::CMD_MEM_WRITE, 3'b100);
    wait_drain();
    write_base(0, 32'h1000_0000);
    write_base(1, 32'h2000_0000);
    write_base(2, 32'h3000_0000);
    // Three of four written, still no base
    send_packet(2, cache_req_pkg::CMD_MEM_READ, 3'b010);
    wait_drain();
    write_base(3, 32'h4000_0000);
    send_packet(0, cache_req_pkg::CMD_MEM_READ, 3'b001);
    send_packet(1, cache_req_pkg::CMD_MEM_WRITE, 3'b010);
    send_packet(2, cache_req_pkg::CMD_MEM_READ, 3'b100);
    send_packet(0, cache_req_pkg::CMD_MEM_WRITE, 3'b000);
    // Two bits set falls back to buffer_0
    send_packet(1, cache_req_pkg::CMD_MEM_READ, 3'b011);
    wait_drain();
    finish_test();
  endtask

  task automatic test_command_filter();
    int grants_before;
    int outs_before;
    start_test("command_filter");
    grants_before = grant_count;
    outs_before   = out_count;
    send_packet(1, cache_req_pkg::CMD_MEM_WRITE, 3'b010);
    send_packet(1, cache_req_pkg::CMD_MEM_RESPONSE, 3'b010);
    send_packet(1, cache_req_pkg::CMD_MEM_READ, 3'b010);
    send_packet(1, cache_req_pkg::CMD_ENGINE, 3'b001);
    send_packet(1, cache_req_pkg::CMD_INVALID, 3'b100);
    send_packet(1, cache_req_pkg::CMD_MEM_WRITE, 3'b000);
    wait_drain();
    check_value("grants", 6, 32'(grant_count - grants_before));
    check_value("outputs", 3, 32'(out_count - outs_before));
    finish_test();
  endtask

  task automatic test_round_robin();
    int prev;
    int grants_before;
    start_test("round_robin");
    prev          = last_grant;
    grants_before = grant_count;
    grant_log.delete();
    fork
      send_burst(0, 3);
      send_burst(1, 3);
      send_burst(2, 3);
    join
    foreach (grant_log[k]) begin
      check_value("grant order", 32'((prev + 1) % cache_req_pkg::NUM_REQUESTORS),
                  32'(grant_log[k]));
      prev = grant_log[k];
    end
    wait_drain();
    check_value("grant count", 9, 32'(grant_count - grants_before));
    finish_test();
  endtask

  task automatic test_back_pressure();
    int waited;
    int stalled_grants;
    int outs_before;
    start_test("back_pressure");
    cache_ready = 1'b0;
    outs_before = out_count;
    fork
      send_burst(0, 6);
      send_burst(1, 6);
      send_burst(2, 6);
      begin
        waited = 0;
        while (!prog_full && waited < DRAIN_LIMIT) begin
          next_cycle();
          waited++;
        end
        if (!prog_full) begin
          error_count++;
          $display("error in %s: prog_full never rose with the cache stalled", test_name);
        end
        // One grant may still be on its way
        next_cycle();
        stalled_grants = grant_count;
        repeat (8) next_cycle();
        check_value("grants while prog_full", 32'(stalled_grants), 32'(grant_count));
        check_value("prog_full held", 1, 32'(prog_full));
        check_value("outputs while stalled", 32'(outs_before), 32'(out_count));
        cache_ready = 1'b1;
      end
    join
    wait_drain();
    check_value("prog_full after drain", 0, 32'(prog_full));
    finish_test();
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    void'($urandom(32'h970d));
    ap_clk         = 1'b0;
    areset_control = 1'b1;
    req_valid      = '0;
    for (int i = 0; i < cache_req_pkg::NUM_REQUESTORS; i++) begin
      req_cmd[i]       = cache_req_pkg::CMD_INVALID;
      req_buffer_id[i] = '0;
      req_offset[i]    = '0;
      req_wdata[i]     = '0;
    end
    desc_wr_en    = 1'b0;
    desc_wr_index = '0;
    desc_wr_base  = '0;
    cache_ready   = 1'b1;
    tb_written    = '0;
    // Arbiter search after reset starts at requestor 0
    last_grant    = cache_req_pkg::NUM_REQUESTORS - 1;

    test_reset();
    test_translation();
    test_command_filter();
    test_round_robin();
    test_back_pressure();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, test_fail_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_cache_request_generator

// File: vlog.f
source/cache_req_pkg.sv
source/buffer_descriptor_regs.sv
source/request_arbiter.sv
source/cache_request_builder.sv
source/request_fifo.sv
source/cache_request_generator.sv
tb/tb_cache_request_generator.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_cache_request_generator \
  -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_cache_request_generator)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
